// File: hw/ising_params.svh
// Ising core sizing
// Spin count, weight widths, memory depth and register map
`ifndef ISING_PARAMS_SVH
`define ISING_PARAMS_SVH

`define ISING_NUM_SPIN 8
`define ISING_BIT_J 4
`define ISING_BIT_H 4

`define ISING_MEM_DEPTH 9
`define ISING_BIAS_ADDR 8

// Register port
`define ISING_REG_AW 4
`define ISING_REG_CTRL 0
`define ISING_REG_PRESET 1
`define ISING_REG_STATUS 2

`endif

// File: hw/ising_cfg_pkg.sv
// Ising core control types
// Operating mode and the two views of a register write word
package ising_cfg_pkg;

    `include "ising_params.svh"

    typedef enum logic [1:0] {
        MODE_IDLE    = 2'd0,
        MODE_LOAD    = 2'd1,
        MODE_COMPUTE = 2'd2,
        MODE_DEBUG   = 2'd3
    } ising_mode_e;

    typedef struct packed {
        logic [20:0] spare;
        logic [7:0]  sweeps;
        logic        start;
        ising_mode_e mode;
    } ctrl_word_t;

    typedef struct packed {
        logic [31-`ISING_NUM_SPIN:0] spare;
        logic [`ISING_NUM_SPIN-1:0]  spins;
    } preset_word_t;

    // Register address picks the view
    typedef union packed {
        ctrl_word_t   ctrl;
        preset_word_t preset;
    } reg_word_u;

endpackage

// File: hw/ising_mem_pkg.sv
// Ising core memory types
// Weight memory address and the coupling row / bias word layout
package ising_mem_pkg;

    `include "ising_params.svh"

    typedef logic [3:0] weight_addr_t;

    typedef logic signed [`ISING_BIT_J-1:0] weight_field_t;

    // Field j of row i is J_ij, field i of the bias word is h_i
    typedef weight_field_t [`ISING_NUM_SPIN-1:0] weight_word_t;

endpackage

// File: hw/ising_if.sv
// Ising core internal links
// Weight memory read port and the spin array port
`timescale 1ns/1ps
`include "ising_params.svh"

interface weight_rd_if import ising_mem_pkg::*; ();

    logic         req_valid;
    logic         req_ready;
    weight_addr_t addr;
    logic         rvalid;
    weight_word_t rdata;

    modport loader (output req_valid, addr, input req_ready, rvalid, rdata);
    modport mem (input req_valid, addr, output req_ready, rvalid, rdata);

endinterface

interface spin_array_if import ising_mem_pkg::*; ();

    // Weight load
    logic                               weight_wen;
    weight_addr_t                       weight_addr;
    weight_word_t                       weight_data;
    // Spin preset and per-spin update
    logic                               spin_wen;
    logic [`ISING_NUM_SPIN-1:0]         spin_wdata;
    logic                               compute_en;
    logic [$clog2(`ISING_NUM_SPIN)-1:0] compute_idx;
    logic                               upd_valid;
    logic                               upd_ready;
    logic                               upd_spin;
    logic [`ISING_NUM_SPIN-1:0]         spins;

    modport loader (output weight_wen, weight_addr, weight_data);
    modport ctrl (
        output spin_wen, spin_wdata, compute_en, compute_idx, upd_ready,
        input  upd_valid, upd_spin, spins
    );
    modport array (
        input  weight_wen, weight_addr, weight_data, spin_wen, spin_wdata,
        input  compute_en, compute_idx, upd_ready,
        output upd_valid, upd_spin, spins
    );

endinterface

// File: hw/ising_reg_file.sv
// Ising core register file
// Holds mode, sweep count and preset, pulses start, returns status
`timescale 1ns/1ps
`include "ising_params.svh"

module ising_reg_file import ising_cfg_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       reg_valid_i,
    output logic                       reg_ready_o,
    input  logic                       reg_write_i,
    input  logic [`ISING_REG_AW-1:0]   reg_addr_i,
    input  logic [31:0]                reg_wdata_i,
    output logic                       reg_rvalid_o,
    output logic [31:0]                reg_rdata_o,
    output ising_mode_e                mode_o,
    output logic [7:0]                 sweeps_o,
    output logic [`ISING_NUM_SPIN-1:0] preset_o,
    output logic                       start_o,
    input  logic [`ISING_NUM_SPIN-1:0] spins_i,
    input  logic                       load_done_i,
    input  logic                       done_i
);

    reg_word_u    wr_word;
    ctrl_word_t   ctrl_q;
    preset_word_t preset_q;
    logic         wr_en;
    logic         rd_en;
    logic [31:0]  rd_data;

    assign reg_ready_o = 1'b1;
    assign wr_en       = reg_valid_i && reg_write_i;
    assign rd_en       = reg_valid_i && !reg_write_i;
    assign wr_word     = reg_wdata_i;

    assign mode_o   = ctrl_q.mode;
    assign sweeps_o = ctrl_q.sweeps;
    assign preset_o = preset_q.spins;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q       <= '0;
            start_o      <= 1'b0;
            reg_rvalid_o <= 1'b0;
        end else begin
            start_o      <= wr_en && (reg_addr_i == `ISING_REG_CTRL) && wr_word.ctrl.start;
            reg_rvalid_o <= rd_en;
            if (wr_en && reg_addr_i == `ISING_REG_CTRL) begin
                ctrl_q <= wr_word.ctrl;
            end
        end
    end

    always_comb begin
        case (reg_addr_i)
            `ISING_REG_CTRL:   rd_data = ctrl_q;
            `ISING_REG_PRESET: rd_data = preset_q;
            `ISING_REG_STATUS: rd_data = {{(30-`ISING_NUM_SPIN){1'b0}}, done_i, load_done_i, spins_i};
            default:           rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && reg_addr_i == `ISING_REG_PRESET) begin
            preset_q <= wr_word.preset;
        end
        if (rd_en) begin
            reg_rdata_o <= rd_data;
        end
    end

    // Status is read only for the host
    a_no_status_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !(wr_en && reg_addr_i == `ISING_REG_STATUS));

endmodule

// File: hw/weight_mem.sv
// Weight memory
// Nine words of couplings and bias; host write port, loader read port
`timescale 1ns/1ps
`include "ising_params.svh"

module weight_mem
    import ising_cfg_pkg::*;
    import ising_mem_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         mem_wr_valid_i,
    output logic         mem_wr_ready_o,
    input  weight_addr_t mem_wr_addr_i,
    input  weight_word_t mem_wr_data_i,
    input  ising_mode_e  mode_i,
    weight_rd_if.mem     rd
);

    weight_word_t mem_q [`ISING_MEM_DEPTH];
    logic         rd_fire;

    assign mem_wr_ready_o = 1'b1;

    // Loader served only in load mode, host write wins
    assign rd.req_ready = (mode_i == MODE_LOAD) && !mem_wr_valid_i;
    assign rd_fire      = rd.req_valid && rd.req_ready;

    always_ff @(posedge clk_i) begin
        if (mem_wr_valid_i) begin
            mem_q[mem_wr_addr_i] <= mem_wr_data_i;
        end
        if (rd_fire) begin
            rd.rdata <= mem_q[rd.addr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd.rvalid <= 1'b0;
        end else begin
            rd.rvalid <= rd_fire;
        end
    end

    a_wr_addr_range: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_wr_valid_i |-> mem_wr_addr_i < `ISING_MEM_DEPTH);
    a_rd_addr_range: assert property (@(posedge clk_i) disable iff (reset_i)
        rd.req_valid |-> rd.addr < `ISING_MEM_DEPTH);

endmodule

// File: hw/weight_loader.sv
// Weight loader
// Copies coupling rows and the bias word from memory into the spin array
// on entry into load mode
`timescale 1ns/1ps
`include "ising_params.svh"

module weight_loader
    import ising_cfg_pkg::*;
    import ising_mem_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  ising_mode_e  mode_i,
    weight_rd_if.loader  rd,
    spin_array_if.loader arr,
    output logic         load_done_o
);

    ising_mode_e  mode_q;
    logic         busy_q;
    logic         pend_q;
    weight_addr_t addr_q;
    logic         entry;

    assign entry = (mode_i == MODE_LOAD) && (mode_q != MODE_LOAD);

    // At most one read in flight
    assign rd.req_valid = busy_q && !pend_q;
    assign rd.addr      = addr_q;

    // Returned word goes to the same address in the array
    assign arr.weight_wen  = busy_q && rd.rvalid;
    assign arr.weight_addr = addr_q;
    assign arr.weight_data = rd.rdata;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mode_q      <= MODE_IDLE;
            busy_q      <= 1'b0;
            pend_q      <= 1'b0;
            addr_q      <= '0;
            load_done_o <= 1'b0;
        end else begin
            mode_q <= mode_i;
            if (mode_i != MODE_LOAD) begin
                busy_q      <= 1'b0;
                pend_q      <= 1'b0;
                load_done_o <= 1'b0;
            end else if (entry) begin
                busy_q <= 1'b1;
                pend_q <= 1'b0;
                addr_q <= '0;
            end else if (busy_q) begin
                if (rd.req_valid && rd.req_ready) begin
                    pend_q <= 1'b1;
                end
                if (rd.rvalid) begin
                    pend_q <= 1'b0;
                    if (addr_q == `ISING_BIAS_ADDR) begin
                        busy_q      <= 1'b0;
                        load_done_o <= 1'b1;
                    end else begin
                        addr_q <= addr_q + 4'd1;
                    end
                end
            end
        end
    end

endmodule

// File: hw/spin_array.sv
// Spin array
// Digital stand-in for the analog macro: weight storage, spin state
// and single-spin local field evaluation
`timescale 1ns/1ps
`include "ising_params.svh"

module spin_array import ising_mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    spin_array_if.array arr
);

    localparam int FIELD_W = 10;
    localparam int IDX_W   = $clog2(`ISING_NUM_SPIN);

    weight_word_t                 j_q [`ISING_NUM_SPIN];
    weight_word_t                 h_q;
    weight_word_t                 row;
    logic [`ISING_NUM_SPIN-1:0]   spins_q;
    logic [IDX_W-1:0]             idx_q;
    logic signed [FIELD_W-1:0]    field;
    logic                         next_bit;

    assign arr.spins = spins_q;

    //////////////////////////////
    // Weight storage
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (arr.weight_wen) begin
            if (arr.weight_addr == `ISING_BIAS_ADDR) begin
                h_q <= arr.weight_data;
            end else begin
                j_q[arr.weight_addr[IDX_W-1:0]] <= arr.weight_data;
            end
        end
    end

    //////////////////////////////
    // Local field
    //////////////////////////////
    always_comb begin
        row   = j_q[arr.compute_idx];
        field = FIELD_W'($signed(h_q[arr.compute_idx]));
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            // Self coupling does not count
            if (j != int'(arr.compute_idx)) begin
                if (spins_q[j]) begin
                    field = field + FIELD_W'($signed(row[j]));
                end else begin
                    field = field - FIELD_W'($signed(row[j]));
                end
            end
        end
        if (field > 0) begin
            next_bit = 1'b1;
        end else if (field < 0) begin
            next_bit = 1'b0;
        end else begin
            next_bit = spins_q[arr.compute_idx];
        end
    end

    // Result held until the controller takes it
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            arr.upd_valid <= 1'b0;
            spins_q       <= '0;
        end else if (arr.spin_wen) begin
            spins_q <= arr.spin_wdata;
        end else if (arr.compute_en) begin
            arr.upd_valid <= 1'b1;
        end else if (arr.upd_valid && arr.upd_ready) begin
            arr.upd_valid  <= 1'b0;
            spins_q[idx_q] <= arr.upd_spin;
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr.compute_en) begin
            arr.upd_spin <= next_bit;
            idx_q        <= arr.compute_idx;
        end
    end

    a_no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
        arr.compute_en |-> !arr.upd_valid);

endmodule

// File: hw/anneal_controller.sv
// Anneal controller
// Writes the preset spins, then runs the requested sweeps spin by spin
`timescale 1ns/1ps
`include "ising_params.svh"

module anneal_controller import ising_cfg_pkg::*; (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  ising_mode_e                mode_i,
    input  logic                       start_i,
    input  logic [7:0]                 sweeps_i,
    input  logic [`ISING_NUM_SPIN-1:0] preset_i,
    spin_array_if.ctrl                 arr,
    output logic                       done_o
);

    localparam int IDX_W = $clog2(`ISING_NUM_SPIN);

    typedef enum logic [1:0] {S_IDLE, S_PRESET, S_ISSUE, S_WAIT} state_e;

    state_e           state_q;
    logic [IDX_W-1:0] idx_q;
    logic [7:0]       sweep_q;
    logic [7:0]       sweeps_q;
    logic             run_ok;

    assign run_ok = (mode_i == MODE_COMPUTE) || (mode_i == MODE_DEBUG);

    assign arr.spin_wen    = (state_q == S_PRESET);
    assign arr.spin_wdata  = preset_i;
    assign arr.compute_en  = (state_q == S_ISSUE);
    assign arr.compute_idx = idx_q;
    assign arr.upd_ready   = (state_q == S_WAIT);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            sweep_q <= '0;
            done_o  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i && run_ok) begin
                        done_o  <= 1'b0;
                        state_q <= S_PRESET;
                    end
                end
                S_PRESET: begin
                    idx_q   <= '0;
                    sweep_q <= '0;
                    if (sweeps_q == 8'd0) begin
                        done_o  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: state_q <= S_WAIT;
                S_WAIT: begin
                    if (arr.upd_valid) begin
                        idx_q <= idx_q + 1'b1;
                        state_q <= S_ISSUE;
                        // Last spin closes a sweep
                        if (idx_q == IDX_W'(`ISING_NUM_SPIN - 1)) begin
                            sweep_q <= sweep_q + 8'd1;
                            if (sweep_q == sweeps_q - 8'd1) begin
                                done_o  <= 1'b1;
                                state_q <= S_IDLE;
                            end
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Sweep count captured with the start
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && start_i) begin
            sweeps_q <= sweeps_i;
        end
    end

endmodule

// File: hw/ising_core_top.sv
// Ising core top level
// Register file, weight memory, loader, spin array and anneal controller
`timescale 1ns/1ps
`include "ising_params.svh"

module ising_core_top
    import ising_cfg_pkg::*;
    import ising_mem_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             reset_i,
    // Register port
    input  logic                             reg_valid_i,
    output logic                             reg_ready_o,
    input  logic                             reg_write_i,
    input  logic [`ISING_REG_AW-1:0]         reg_addr_i,
    input  logic [31:0]                      reg_wdata_i,
    output logic                             reg_rvalid_o,
    output logic [31:0]                      reg_rdata_o,
    // Weight memory write port
    input  logic                             mem_wr_valid_i,
    output logic                             mem_wr_ready_o,
    input  logic [$bits(weight_addr_t)-1:0]  mem_wr_addr_i,
    input  logic [$bits(weight_word_t)-1:0]  mem_wr_data_i,
    // Results
    output logic [`ISING_NUM_SPIN-1:0]       spins_o,
    output logic                             done_o
);

    ising_mode_e                mode;
    logic [7:0]                 sweeps;
    logic [`ISING_NUM_SPIN-1:0] preset;
    logic                       start;
    logic                       load_done;

    weight_rd_if  rd_if ();
    spin_array_if arr_if ();

    assign spins_o = arr_if.spins;

    //////////////////////////////
    // Host side
    //////////////////////////////
    ising_reg_file ising_reg_file_inst (
        .clk_i, .reset_i,
        .reg_valid_i, .reg_ready_o, .reg_write_i, .reg_addr_i, .reg_wdata_i,
        .reg_rvalid_o, .reg_rdata_o,
        .mode_o      (mode),
        .sweeps_o    (sweeps),
        .preset_o    (preset),
        .start_o     (start),
        .spins_i     (arr_if.spins),
        .load_done_i (load_done),
        .done_i      (done_o)
    );

    weight_mem weight_mem_inst (
        .clk_i, .reset_i,
        .mem_wr_valid_i, .mem_wr_ready_o, .mem_wr_addr_i, .mem_wr_data_i,
        .mode_i (mode),
        .rd     (rd_if)
    );

    //////////////////////////////
    // Load and anneal
    //////////////////////////////
    weight_loader weight_loader_inst (
        .clk_i, .reset_i,
        .mode_i      (mode),
        .rd          (rd_if),
        .arr         (arr_if),
        .load_done_o (load_done)
    );

    spin_array spin_array_inst (.clk_i, .reset_i, .arr (arr_if));

    anneal_controller anneal_controller_inst (
        .clk_i, .reset_i,
        .mode_i   (mode),
        .start_i  (start),
        .sweeps_i (sweeps),
        .preset_i (preset),
        .arr      (arr_if),
        .done_o
    );

endmodule

// File: verif/tb_ising_core.sv
// Ising core testbench
// Directed tests of register access, weight load, sweeps and mode gating
// checked against a software model of the spin update
`timescale 1ns/1ps
`include "ising_params.svh"

module tb_ising_core
    import ising_cfg_pkg::*;
    import ising_mem_pkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int N          = `ISING_NUM_SPIN;

    logic                     clk_i;
    logic                     reset_i;
    logic                     reg_valid_i;
    logic                     reg_ready_o;
    logic                     reg_write_i;
    logic [`ISING_REG_AW-1:0] reg_addr_i;
    logic [31:0]              reg_wdata_i;
    logic                     reg_rvalid_o;
    logic [31:0]              reg_rdata_o;
    logic                     mem_wr_valid_i;
    logic                     mem_wr_ready_o;
    weight_addr_t             mem_wr_addr_i;
    weight_word_t             mem_wr_data_i;
    logic [N-1:0]             spins_o;
    logic                     done_o;

    // Model copies of the weights
    weight_word_t j_m [N];
    weight_word_t h_m;

    integer seed;
    int     value_errs;
    int     other_errs;
    int     cycles;

    ising_core_top ising_core_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Bus tasks
    //////////////////////////////
    task automatic reg_write(input logic [`ISING_REG_AW-1:0] addr, input logic [31:0] data);
        reg_valid_i = 1'b1;
        reg_write_i = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        check_flag("reg_ready_o", reg_ready_o, 1'b1);
        @(posedge clk_i);
        #1;
        reg_valid_i = 1'b0;
        reg_write_i = 1'b0;
    endtask

    task automatic reg_read(input logic [`ISING_REG_AW-1:0] addr, output logic [31:0] data);
        reg_valid_i = 1'b1;
        reg_write_i = 1'b0;
        reg_addr_i  = addr;
        @(posedge clk_i);
        #1;
        reg_valid_i = 1'b0;
        while (!reg_rvalid_o) begin
            @(posedge clk_i);
            #1;
        end
        data = reg_rdata_o;
    endtask

    task automatic mem_write(input weight_addr_t addr, input weight_word_t data);
        mem_wr_valid_i = 1'b1;
        mem_wr_addr_i  = addr;
        mem_wr_data_i  = data;
        check_flag("mem_wr_ready_o", mem_wr_ready_o, 1'b1);
        @(posedge clk_i);
        #1;
        mem_wr_valid_i = 1'b0;
    endtask

    //////////////////////////////
    // Model and compare tasks
    //////////////////////////////
    // One sweep in index order, newest spin values, self coupling skipped
    function automatic logic [N-1:0] model_sweep(input logic [N-1:0] s);
        logic [N-1:0] r;
        int           field;
        r = s;
        for (int i = 0; i < N; i++) begin
            field = int'($signed(h_m[i]));
            for (int j = 0; j < N; j++) begin
                if (j != i && r[j]) begin
                    field += int'($signed(j_m[i][j]));
                end else if (j != i) begin
                    field -= int'($signed(j_m[i][j]));
                end
            end
            if (field > 0) begin
                r[i] = 1'b1;
            end else if (field < 0) begin
                r[i] = 1'b0;
            end
        end
        return r;
    endfunction

    task automatic check_spins(input string name, input logic [N-1:0] got, input logic [N-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // Test steps
    //////////////////////////////
    task automatic load_weights(input bit zero);
        weight_word_t w;
        ctrl_word_t   c;
        logic [31:0]  st;
        for (int a = 0; a < `ISING_MEM_DEPTH; a++) begin
            w = '0;
            if (!zero) begin
                w = $random(seed);
            end
            if (a == `ISING_BIAS_ADDR) begin
                h_m = w;
            end else begin
                j_m[a] = w;
            end
            mem_write(weight_addr_t'(a), w);
        end
        c      = '0;
        c.mode = MODE_LOAD;
        reg_write(`ISING_REG_CTRL, c);
        @(posedge clk_i);
        #1;
        // Host rewrite of row 3 collides with the first loader read
        w = '0;
        if (!zero) begin
            w = $random(seed);
        end
        j_m[3] = w;
        mem_write(4'd3, w);
        st = '0;
        while (!st[8]) begin
            reg_read(`ISING_REG_STATUS, st);
        end
    endtask

    task automatic run_anneal(input ising_mode_e mode, input logic [7:0] sweeps,
                              input logic [N-1:0] preset, output logic [N-1:0] result);
        ctrl_word_t   c;
        logic [N-1:0] exp;
        logic [31:0]  st;
        c        = '0;
        c.mode   = mode;
        c.start  = 1'b1;
        c.sweeps = sweeps;
        reg_write(`ISING_REG_PRESET, 32'(preset));
        reg_write(`ISING_REG_CTRL, c);
        // Start pulse is out, done drops on this edge
        @(posedge clk_i);
        #1;
        check_flag("done_o after start", done_o, 1'b0);
        while (!done_o) begin
            @(posedge clk_i);
            #1;
        end
        exp = preset;
        repeat (sweeps) exp = model_sweep(exp);
        check_spins("spins_o", spins_o, exp);
        reg_read(`ISING_REG_STATUS, st);
        check_word("status after run", st, 32'({2'b10, exp}));
        result = spins_o;
    endtask

    task automatic test_registers();
        ctrl_word_t  c;
        logic [31:0] rd;
        reg_read(`ISING_REG_STATUS, rd);
        check_word("status after reset", rd, 32'd0);
        c        = '0;
        c.sweeps = 8'h5a;
        c.spare  = 21'h0c3a1;
        reg_write(`ISING_REG_CTRL, c);
        reg_write(`ISING_REG_PRESET, 32'h0000_00a5);
        reg_read(`ISING_REG_CTRL, rd);
        check_word("ctrl readback", rd, c);
        reg_read(`ISING_REG_PRESET, rd);
        check_word("preset readback", rd, 32'h0000_00a5);
    endtask

    // Run before any anneal, done is still low from reset
    task automatic test_idle_gating();
        ctrl_word_t c;
        logic       seen;
        c        = '0;
        c.start  = 1'b1;
        c.sweeps = 8'd1;
        reg_write(`ISING_REG_CTRL, c);
        seen = 1'b0;
        repeat (50) begin
            @(posedge clk_i);
            #1;
            seen |= done_o;
        end
        check_flag("done_o in idle mode", seen, 1'b0);
        check_spins("spins_o in idle mode", spins_o, '0);
    endtask

    task automatic test_sweeps();
        logic [N-1:0] p;
        logic [N-1:0] res;
        logic [N-1:0] res_dbg;
        load_weights(1'b0);
        p = N'($random(seed));
        run_anneal(MODE_COMPUTE, 8'd1, p, res);
        p = N'($random(seed));
        run_anneal(MODE_COMPUTE, 8'd4, p, res);
        run_anneal(MODE_COMPUTE, 8'd7, res, res);
        // Zero field keeps every spin
        load_weights(1'b1);
        p = N'($random(seed));
        run_anneal(MODE_COMPUTE, 8'd3, p, res);
        check_spins("spins_o with zero weights", res, p);
        load_weights(1'b0);
        p = N'($random(seed));
        run_anneal(MODE_COMPUTE, 8'd0, p, res);
        check_spins("spins_o with zero sweeps", res, p);
        // Debug mode runs like compute
        p = N'($random(seed));
        run_anneal(MODE_COMPUTE, 8'd2, p, res);
        run_anneal(MODE_DEBUG, 8'd2, p, res_dbg);
        check_spins("spins_o in debug mode", res_dbg, res);
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        other_errs++;
        $display("Timeout after %0d cycles, DUT never finished the tests", cycles);
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed           = 32'hf228;
        value_errs     = 0;
        other_errs     = 0;
        reset_i        = 1'b1;
        reg_valid_i    = 1'b0;
        reg_write_i    = 1'b0;
        reg_addr_i     = '0;
        reg_wdata_i    = '0;
        mem_wr_valid_i = 1'b0;
        mem_wr_addr_i  = '0;
        mem_wr_data_i  = '0;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        check_flag("done_o after reset", done_o, 1'b0);
        check_flag("reg_rvalid_o after reset", reg_rvalid_o, 1'b0);
        test_registers();
        test_idle_gating();
        test_sweeps();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+hw
hw/ising_cfg_pkg.sv
hw/ising_mem_pkg.sv
hw/ising_if.sv
hw/ising_reg_file.sv
hw/weight_mem.sv
hw/weight_loader.sv
hw/spin_array.sv
hw/anneal_controller.sv
hw/ising_core_top.sv
verif/tb_ising_core.sv

// File: Makefile
# Verilator simulation of the Ising core testbench

TOP       ?= tb_ising_core
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
